// ==== verilog/debug_consts.svh ====
`ifndef DEBUG_CONSTS_SVH
`define DEBUG_CONSTS_SVH

// instruction, register and data memory word width
`define DU_DATA_W 32

// instruction memory, register and data memory address width
`define DU_ADDR_W 8

// registers sent in every dump
`define DU_NUM_REGS 32

// data memory words scanned for dirty flags
`define DU_MEM_WORDS 16

// serial bit time in clock cycles, kept short for simulation
`define DU_CLKS_PER_BIT 8

`endif

// ==== verilog/debug_pkg.sv ====
package debug_pkg;

	// run control and dump sequencing
	typedef enum logic [3:0]
	{
		idle_load,   // program still arriving
		wait_mode,   // waiting for a mode byte
		step_run,    // one enabled pipeline cycle
		cont_run,    // enabled until halt
		send_pc,
		send_cycles,
		read_reg,    // register address presented
		send_reg,    // four bytes of the register word
		read_mem,    // memory address presented, dirty flag checked
		send_addr,
		send_mem     // four bytes of the memory word
	} du_state_t;

	// mode bytes from the host
	typedef enum logic [7:0]
	{
		mode_step     = 8'h04,
		mode_continue = 8'h10
	} du_mode_t;

endpackage

// ==== verilog/du_byte_if.sv ====
`timescale 1ns/100ps

interface du_byte_if;
	logic [7:0] rx_byte;  // last byte off the line
	logic       rx_valid; // one cycle per received byte
	logic [7:0] tx_byte;
	logic       tx_start; // one cycle, only while tx_busy is low
	logic       tx_done;  // end of stop bit
	logic       tx_busy;  // frame in progress

	modport rx_side (output rx_byte, output rx_valid);
	modport tx_side (input tx_byte, input tx_start, output tx_done, output tx_busy);
	modport loader_side (input rx_byte, input rx_valid);
	modport control_side (output tx_byte, output tx_start, input tx_done, input tx_busy);
endinterface

// ==== verilog/uart_rx.sv ====
`timescale 1ns/100ps
`include "debug_consts.svh"

module uart_rx
(
	input  logic       i_clock,
	input  logic       i_reset,
	input  logic       i_rx,
	du_byte_if.rx_side byte_if
);
	localparam int CNT_W = $clog2(`DU_CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] MID_CNT = CNT_W'(`DU_CLKS_PER_BIT / 2 - 1);
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`DU_CLKS_PER_BIT - 1);

	logic [1:0]       rx_sync; // two flop synchronizer
	logic             busy;
	logic [CNT_W-1:0] cyc_cnt;
	logic [3:0]       bit_cnt; // 0 start, 1..8 data, 9 stop
	logic [7:0]       shift_q;
	logic             sample;

	assign sample = busy && (cyc_cnt == MID_CNT); // middle of the bit
	assign byte_if.rx_byte = shift_q;

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			rx_sync <= 2'b11;
			busy <= 1'b0;
			cyc_cnt <= '0;
			bit_cnt <= '0;
			byte_if.rx_valid <= 1'b0;
		end
		else
		begin
			rx_sync <= {rx_sync[0], i_rx};
			byte_if.rx_valid <= 1'b0;
			if (!busy)
			begin
				cyc_cnt <= '0;
				bit_cnt <= '0;
				if (!rx_sync[1])
					busy <= 1'b1; // falling edge of a start bit
			end
			else
			begin
				cyc_cnt <= (cyc_cnt == LAST_CNT) ? '0 : cyc_cnt + 1'b1;
				if (sample)
				begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == 4'd0 && rx_sync[1])
						busy <= 1'b0; // line went back high, only a glitch
					else if (bit_cnt == 4'd9)
					begin
						busy <= 1'b0;
						byte_if.rx_valid <= rx_sync[1]; // bad stop bit drops the byte
					end
				end
			end
		end
	end

	// data arrives lsb first
	always_ff @(posedge i_clock)
	begin
		if (sample && bit_cnt >= 4'd1 && bit_cnt <= 4'd8)
			shift_q <= {rx_sync[1], shift_q[7:1]};
	end
endmodule

// ==== verilog/uart_tx.sv ====
`timescale 1ns/100ps
`include "debug_consts.svh"

module uart_tx
(
	input  logic       i_clock,
	input  logic       i_reset,
	output logic       o_tx,
	du_byte_if.tx_side byte_if
);
	localparam int CNT_W = $clog2(`DU_CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`DU_CLKS_PER_BIT - 1);

	logic             busy;
	logic [CNT_W-1:0] cyc_cnt;
	logic [3:0]       bit_cnt; // bit now on the line, 0 start, 9 stop
	logic [7:0]       shift_q;
	logic             bit_end;
	logic             shift_out;

	assign bit_end = busy && (cyc_cnt == LAST_CNT);
	assign shift_out = bit_end && (bit_cnt < 4'd8);
	assign byte_if.tx_busy = busy;

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			busy <= 1'b0;
			cyc_cnt <= '0;
			bit_cnt <= '0;
			o_tx <= 1'b1; // idle line
			byte_if.tx_done <= 1'b0;
		end
		else
		begin
			byte_if.tx_done <= 1'b0;
			if (!busy)
			begin
				if (byte_if.tx_start)
				begin
					busy <= 1'b1;
					cyc_cnt <= '0;
					bit_cnt <= '0;
					o_tx <= 1'b0; // start bit
				end
			end
			else if (bit_end)
			begin
				cyc_cnt <= '0;
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == 4'd9)
				begin
					busy <= 1'b0;
					byte_if.tx_done <= 1'b1;
					o_tx <= 1'b1;
				end
				else if (bit_cnt == 4'd8)
					o_tx <= 1'b1; // stop bit
				else
					o_tx <= shift_q[0];
			end
			else
				cyc_cnt <= cyc_cnt + 1'b1;
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (!busy && byte_if.tx_start)
			shift_q <= byte_if.tx_byte;
		else if (shift_out)
			shift_q <= {1'b0, shift_q[7:1]};
	end
endmodule

// ==== verilog/du_loader.sv ====
`timescale 1ns/100ps
`include "debug_consts.svh"

module du_loader
(
	input  logic                  i_clock,
	input  logic                  i_reset,
	du_byte_if.loader_side        byte_if,
	output logic                  o_imem_we,
	output logic [`DU_ADDR_W-1:0] o_imem_addr,
	output logic [`DU_DATA_W-1:0] o_imem_data,
	output logic                  o_load_done,
	output logic                  o_mode_valid,
	output debug_pkg::du_mode_t   o_mode
);
	import debug_pkg::*;

	logic                  got_count; // first byte seen
	logic [`DU_ADDR_W-1:0] word_total;
	logic [1:0]            byte_cnt;  // byte position inside the word
	logic                  loading;
	logic                  last_word;

	assign loading = got_count && !o_load_done;
	assign last_word = (o_imem_addr == word_total - 1'b1);

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			got_count <= 1'b0;
			word_total <= '0;
			byte_cnt <= '0;
			o_imem_we <= 1'b0;
			o_imem_addr <= '0;
			o_load_done <= 1'b0;
			o_mode_valid <= 1'b0;
		end
		else
		begin
			o_imem_we <= 1'b0;
			o_mode_valid <= 1'b0;
			if (o_imem_we)
			begin
				o_imem_addr <= o_imem_addr + 1'b1;
				if (last_word)
					o_load_done <= 1'b1;
			end
			if (byte_if.rx_valid)
			begin
				if (!got_count)
				begin
					got_count <= 1'b1;
					word_total <= byte_if.rx_byte;
					if (byte_if.rx_byte == 8'd0)
						o_load_done <= 1'b1; // empty program
				end
				else if (loading)
				begin
					byte_cnt <= byte_cnt + 1'b1;
					if (byte_cnt == 2'd3)
						o_imem_we <= 1'b1; // word complete
				end
				else
					o_mode_valid <= 1'b1;
			end
		end
	end

	// lsb first, so each byte enters at the top and moves down
	always_ff @(posedge i_clock)
	begin
		if (byte_if.rx_valid && loading)
			o_imem_data <= {byte_if.rx_byte, o_imem_data[`DU_DATA_W-1:8]};
		else if (byte_if.rx_valid && o_load_done)
			o_mode <= du_mode_t'(byte_if.rx_byte);
	end
endmodule

// ==== verilog/du_controller.sv ====
`timescale 1ns/100ps
`include "debug_consts.svh"

module du_controller
(
	input  logic                  i_clock,
	input  logic                  i_reset,
	du_byte_if.control_side       byte_if,
	input  logic                  i_load_done,
	input  logic                  i_mode_valid,
	input  debug_pkg::du_mode_t   i_mode,
	input  logic                  i_halt,
	input  logic [`DU_ADDR_W-1:0] i_pc,
	input  logic [`DU_DATA_W-1:0] i_reg_data,
	input  logic [`DU_DATA_W-1:0] i_mem_data,
	input  logic                  i_mem_dirty,
	output logic                  o_pipe_enable,
	output logic [`DU_ADDR_W-1:0] o_reg_addr,
	output logic [`DU_ADDR_W-1:0] o_mem_addr,
	output logic                  o_read_active
);
	import debug_pkg::*;

	localparam int ADDR_W = `DU_ADDR_W;
	localparam logic [ADDR_W-1:0] LAST_REG = ADDR_W'(`DU_NUM_REGS - 1);
	localparam logic [ADDR_W-1:0] LAST_MEM = ADDR_W'(`DU_MEM_WORDS - 1);

	du_state_t  state;
	logic [7:0] cycle_cnt;  // enabled cycles, wraps at 256
	logic [1:0] byte_idx;   // byte of the current word on the line
	logic       tx_pending; // frame started, tx_done not yet seen
	logic       rd_wait;    // memory read latency cycle
	logic       sending;
	logic       start_ok;
	logic       frame_done;
	logic       last_reg;
	logic       last_mem;
	logic [7:0] send_byte;

	assign o_pipe_enable = (state == step_run) || (state == cont_run);
	assign o_read_active = !(state inside {idle_load, wait_mode, step_run, cont_run});
	assign sending = state inside {send_pc, send_cycles, send_reg, send_addr, send_mem};
	assign start_ok = sending && !tx_pending && !byte_if.tx_busy;
	assign frame_done = tx_pending && byte_if.tx_done;
	assign last_reg = (o_reg_addr == LAST_REG);
	assign last_mem = (o_mem_addr == LAST_MEM);

	always_comb
	begin
		case (state)
			send_pc:     send_byte = 8'(i_pc);
			send_cycles: send_byte = cycle_cnt;
			send_reg:    send_byte = i_reg_data[8*byte_idx +: 8];
			send_addr:   send_byte = 8'(o_mem_addr);
			send_mem:    send_byte = i_mem_data[8*byte_idx +: 8];
			default:     send_byte = 8'h00;
		endcase
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			state <= idle_load;
			cycle_cnt <= '0;
			byte_idx <= '0;
			tx_pending <= 1'b0;
			rd_wait <= 1'b0;
			o_reg_addr <= '0;
			o_mem_addr <= '0;
			byte_if.tx_start <= 1'b0;
		end
		else
		begin
			byte_if.tx_start <= start_ok;
			if (start_ok)
				tx_pending <= 1'b1;
			else if (frame_done)
				tx_pending <= 1'b0;
			if (o_pipe_enable)
				cycle_cnt <= cycle_cnt + 1'b1;

			case (state)
				idle_load:
					if (i_load_done)
						state <= wait_mode;
				wait_mode:
					if (i_mode_valid)
					begin
						case (i_mode)
							mode_step:     state <= step_run;
							mode_continue: state <= cont_run;
							default:       state <= wait_mode; // unknown mode byte
						endcase
					end
				step_run:
					state <= send_pc;
				cont_run:
					if (i_halt)
						state <= send_pc;
				send_pc:
					if (frame_done)
						state <= send_cycles;
				send_cycles:
					if (frame_done)
						state <= read_reg;
				read_reg:
					state <= send_reg; // data valid from the next cycle
				send_reg:
					if (frame_done)
					begin
						byte_idx <= byte_idx + 1'b1;
						if (byte_idx == 2'd3)
						begin
							if (last_reg)
							begin
								o_reg_addr <= '0;
								state <= read_mem;
							end
							else
							begin
								o_reg_addr <= o_reg_addr + 1'b1;
								state <= read_reg;
							end
						end
					end
				read_mem:
				begin
					rd_wait <= !rd_wait;
					if (rd_wait)
					begin
						if (i_mem_dirty)
							state <= send_addr;
						else if (last_mem)
						begin
							o_mem_addr <= '0;
							state <= wait_mode; // scan ends on a clean word
						end
						else
							o_mem_addr <= o_mem_addr + 1'b1;
					end
				end
				send_addr:
					if (frame_done)
						state <= send_mem;
				send_mem:
					if (frame_done)
					begin
						byte_idx <= byte_idx + 1'b1;
						if (byte_idx == 2'd3)
						begin
							if (last_mem)
							begin
								o_mem_addr <= '0;
								state <= wait_mode;
							end
							else
							begin
								o_mem_addr <= o_mem_addr + 1'b1;
								state <= read_mem;
							end
						end
					end
				default:
					state <= idle_load;
			endcase
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (start_ok)
			byte_if.tx_byte <= send_byte;
	end
endmodule

// ==== verilog/debug_unit.sv ====
`timescale 1ns/100ps
`include "debug_consts.svh"

module debug_unit
(
	input  logic                  i_clock,
	input  logic                  i_reset,
	input  logic                  i_rx,
	output logic                  o_tx,
	output logic                  o_imem_we,
	output logic [`DU_ADDR_W-1:0] o_imem_addr,
	output logic [`DU_DATA_W-1:0] o_imem_data,
	output logic                  o_pipe_enable,
	input  logic                  i_halt,
	input  logic [`DU_ADDR_W-1:0] i_pc,
	output logic [`DU_ADDR_W-1:0] o_reg_addr,
	input  logic [`DU_DATA_W-1:0] i_reg_data,
	output logic [`DU_ADDR_W-1:0] o_mem_addr,
	input  logic [`DU_DATA_W-1:0] i_mem_data,
	input  logic                  i_mem_dirty,
	output logic                  o_read_active
);
	import debug_pkg::*;

	du_byte_if byte_if ();

	logic     load_done;
	logic     mode_valid;
	du_mode_t mode;

	uart_rx rx_i
	(
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_rx    (i_rx),
		.byte_if (byte_if.rx_side)
	);

	uart_tx tx_i
	(
		.i_clock (i_clock),
		.i_reset (i_reset),
		.o_tx    (o_tx),
		.byte_if (byte_if.tx_side)
	);

	du_loader loader_i
	(
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.byte_if      (byte_if.loader_side),
		.o_imem_we    (o_imem_we),
		.o_imem_addr  (o_imem_addr),
		.o_imem_data  (o_imem_data),
		.o_load_done  (load_done),
		.o_mode_valid (mode_valid),
		.o_mode       (mode)
	);

	du_controller ctrl_i
	(
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.byte_if       (byte_if.control_side),
		.i_load_done   (load_done),
		.i_mode_valid  (mode_valid),
		.i_mode        (mode),
		.i_halt        (i_halt),
		.i_pc          (i_pc),
		.i_reg_data    (i_reg_data),
		.i_mem_data    (i_mem_data),
		.i_mem_dirty   (i_mem_dirty),
		.o_pipe_enable (o_pipe_enable),
		.o_reg_addr    (o_reg_addr),
		.o_mem_addr    (o_mem_addr),
		.o_read_active (o_read_active)
	);
endmodule

// ==== verification/debug_unit_properties.sv ====
`timescale 1ns/100ps

module debug_unit_properties
(
	input logic i_clock,
	input logic i_reset,
	input logic i_tx,
	input logic i_tx_busy,
	input logic i_imem_we,
	input logic i_pipe_enable,
	input logic i_read_active,
	input logic i_load_done
);
	// one write pulse per instruction word
	imem_we_single: assert property (@(posedge i_clock) disable iff (i_reset)
		i_imem_we |=> !i_imem_we)
		else $error("o_imem_we high two cycles in a row");

	// the pipeline is frozen while the dump reads registers and memory
	enable_vs_read: assert property (@(posedge i_clock) disable iff (i_reset)
		!(i_pipe_enable && i_read_active))
		else $error("o_pipe_enable high during the dump");

	tx_idle_high: assert property (@(posedge i_clock) disable iff (i_reset)
		!i_tx_busy |-> i_tx)
		else $error("o_tx low while the transmitter is idle");

	enable_after_load: assert property (@(posedge i_clock) disable iff (i_reset)
		!i_load_done |-> !i_pipe_enable)
		else $error("o_pipe_enable high before the program load finished");
endmodule

// ==== verification/debug_unit_tb.sv ====
`timescale 1ns/100ps
`include "debug_consts.svh"

module debug_unit_tb;
	import debug_pkg::*;

	localparam int ADDR_W = `DU_ADDR_W;
	localparam int REG_AW = $clog2(`DU_NUM_REGS);
	localparam int MEM_AW = $clog2(`DU_MEM_WORDS);
	localparam int FRAME_CLKS = 10 * `DU_CLKS_PER_BIT;
	localparam int FRAME_WAIT = 6 * FRAME_CLKS; // covers a full memory scan between frames
	localparam int QUIET_CLKS = 3 * FRAME_CLKS;

	logic                  i_clock = 1'b0;
	logic                  i_reset;
	logic                  i_rx;
	logic                  o_tx;
	logic                  o_imem_we;
	logic [`DU_ADDR_W-1:0] o_imem_addr;
	logic [`DU_DATA_W-1:0] o_imem_data;
	logic                  o_pipe_enable;
	logic                  i_halt = 1'b0;
	logic [`DU_ADDR_W-1:0] i_pc = '0;
	logic [`DU_ADDR_W-1:0] o_reg_addr;
	logic [`DU_DATA_W-1:0] i_reg_data = '0;
	logic [`DU_ADDR_W-1:0] o_mem_addr;
	logic [`DU_DATA_W-1:0] i_mem_data = '0;
	logic                  i_mem_dirty = 1'b0;
	logic                  o_read_active;

	// processor model
	logic [`DU_DATA_W-1:0] regs [`DU_NUM_REGS];
	logic [`DU_DATA_W-1:0] mem [`DU_MEM_WORDS];
	logic                  mem_dirty [`DU_MEM_WORDS];
	int                    en_total = 0;           // enabled cycles since reset
	int                    halt_at = 32'h7fffffff; // en_total value that raises i_halt

	integer                seed = 32'h1dc9;
	logic [7:0]            rx_q [$];               // bytes decoded from o_tx
	logic [`DU_ADDR_W-1:0] we_addr_q [$];
	logic [`DU_DATA_W-1:0] we_data_q [$];

	always #2 i_clock = ~i_clock;

	debug_unit dut_i
	(
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_rx          (i_rx),
		.o_tx          (o_tx),
		.o_imem_we     (o_imem_we),
		.o_imem_addr   (o_imem_addr),
		.o_imem_data   (o_imem_data),
		.o_pipe_enable (o_pipe_enable),
		.i_halt        (i_halt),
		.i_pc          (i_pc),
		.o_reg_addr    (o_reg_addr),
		.i_reg_data    (i_reg_data),
		.o_mem_addr    (o_mem_addr),
		.i_mem_data    (i_mem_data),
		.i_mem_dirty   (i_mem_dirty),
		.o_read_active (o_read_active)
	);

	bind debug_unit debug_unit_properties props_i
	(
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_tx          (o_tx),
		.i_tx_busy     (byte_if.tx_busy),
		.i_imem_we     (o_imem_we),
		.i_pipe_enable (o_pipe_enable),
		.i_read_active (o_read_active),
		.i_load_done   (load_done)
	);

	// synchronous reads, pc advance and halt, plus capture of imem writes
	always @(posedge i_clock)
	begin
		i_reg_data <= regs[o_reg_addr[REG_AW-1:0]];
		i_mem_data <= mem[o_mem_addr[MEM_AW-1:0]];
		i_mem_dirty <= mem_dirty[o_mem_addr[MEM_AW-1:0]];
		if (o_pipe_enable)
		begin
			i_pc <= i_pc + 1'b1;
			en_total = en_total + 1;
		end
		i_halt <= o_pipe_enable && (en_total >= halt_at);
		if (o_imem_we)
		begin
			we_addr_q.push_back(o_imem_addr);
			we_data_q.push_back(o_imem_data);
		end
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_word(input string name, input logic [`DU_DATA_W-1:0] got,
		input logic [`DU_DATA_W-1:0] exp);
		if (got !== exp)
			fail_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_byte(input string name, input logic [$bits(du_mode_t)-1:0] got,
		input logic [$bits(du_mode_t)-1:0] exp);
		if (got !== exp)
			fail_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_addr(input string name, input logic [`DU_ADDR_W-1:0] got,
		input logic [`DU_ADDR_W-1:0] exp);
		if (got !== exp)
			fail_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
	endtask

	function automatic int rand_range(input int lo, input int hi);
		logic [31:0] r;
		r = $random(seed);
		return lo + int'(r % 32'(hi - lo + 1));
	endfunction

	task automatic randomize_model();
		logic [31:0] r;
		for (int i = 0; i < `DU_NUM_REGS; i++)
		begin
			r = $random(seed);
			regs[i] = r;
		end
		for (int i = 0; i < `DU_MEM_WORDS; i++)
		begin
			r = $random(seed);
			mem[i] = r;
			r = $random(seed);
			mem_dirty[i] = r[0];
		end
	endtask

	// host side 8N1 frame sent lsb first
	task automatic send_serial_byte(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			@(posedge i_clock);
			i_rx <= frame[i];
			repeat (`DU_CLKS_PER_BIT - 1) @(posedge i_clock);
		end
	endtask

	task automatic collect_frames();
		logic [7:0] b;
		forever
		begin
			@(posedge i_clock);
			if (!i_reset && o_tx === 1'b0)
			begin
				repeat (`DU_CLKS_PER_BIT / 2 - 1) @(posedge i_clock); // middle of the start bit
				if (o_tx !== 1'b0)
					fail_run("start bit on o_tx ended early");
				for (int i = 0; i < 8; i++)
				begin
					repeat (`DU_CLKS_PER_BIT) @(posedge i_clock);
					b[i] = o_tx;
				end
				repeat (`DU_CLKS_PER_BIT) @(posedge i_clock);
				if (o_tx !== 1'b1)
					fail_run("stop bit missing on o_tx");
				else
					rx_q.push_back(b);
			end
		end
	endtask

	initial
	begin
		collect_frames();
	end

	task automatic pop_frame(output logic [7:0] b);
		int waited;
		waited = 0;
		while (rx_q.size() == 0 && waited < FRAME_WAIT)
		begin
			@(posedge i_clock);
			waited++;
		end
		if (rx_q.size() == 0)
			fail_run("no frame arrived on o_tx in time");
		else
			b = rx_q.pop_front();
	endtask

	task automatic pop_word(output logic [`DU_DATA_W-1:0] w);
		logic [7:0] b;
		for (int k = 0; k < `DU_DATA_W / 8; k++)
		begin
			pop_frame(b);
			w[8*k +: 8] = b;
		end
	endtask

	// nothing may run and nothing may be sent for a while
	task automatic expect_quiet(input string what);
		for (int i = 0; i < QUIET_CLKS; i++)
		begin
			@(posedge i_clock);
			if (o_pipe_enable === 1'b1)
				fail_run($sformatf("o_pipe_enable rose %s", what));
			else if (o_tx === 1'b0)
				fail_run($sformatf("o_tx started a frame %s", what));
		end
		if (rx_q.size() != 0)
			fail_run($sformatf("stray bytes decoded from o_tx %s", what));
	endtask

	task automatic wait_read_idle();
		int waited;
		waited = 0;
		while (o_read_active !== 1'b0 && waited < FRAME_WAIT)
		begin
			@(posedge i_clock);
			waited++;
		end
		if (o_read_active !== 1'b0)
			fail_run("o_read_active stayed high after the last dump frame");
	endtask

	task automatic load_program();
		int n;
		int waited;
		logic [31:0] r;
		logic [`DU_DATA_W-1:0] words [$];
		n = rand_range(1, 12);
		send_serial_byte(8'(n));
		for (int i = 0; i < n; i++)
		begin
			r = $random(seed);
			words.push_back(r);
			for (int k = 0; k < `DU_DATA_W / 8; k++)
				send_serial_byte(r[8*k +: 8]);
		end
		waited = 0;
		while (we_addr_q.size() < n && waited < FRAME_WAIT)
		begin
			@(posedge i_clock);
			waited++;
		end
		repeat (FRAME_CLKS) @(posedge i_clock); // room for an extra pulse to show up
		check_word("o_imem_we pulse count", 32'(we_addr_q.size()), 32'(n));
		for (int i = 0; i < n; i++)
		begin
			check_addr($sformatf("o_imem_addr of write %0d", i), we_addr_q[i], ADDR_W'(i));
			check_word($sformatf("o_imem_data of write %0d", i), we_data_q[i], words[i]);
		end
	endtask

	task automatic run_and_check(input du_mode_t mode);
		int en_before;
		int run_len;
		int halt_len;
		logic [7:0] pc_before;
		logic [7:0] b;
		logic [`DU_DATA_W-1:0] w;
		randomize_model();
		halt_len = rand_range(3, 40);
		en_before = en_total;
		pc_before = i_pc;
		if (mode == mode_continue)
			halt_at = en_total + halt_len;
		else
			halt_at = 32'h7fffffff;
		send_serial_byte(mode);
		pop_frame(b);
		if (o_read_active !== 1'b1)
			fail_run("o_read_active was low while the dump was running");
		run_len = en_total - en_before;
		if (mode == mode_step)
			check_word("o_pipe_enable cycles for step", 32'(run_len), 32'd1);
		else
			check_word("o_pipe_enable cycles for continue", 32'(run_len), 32'(halt_len + 1));
		check_addr("o_tx pc byte", b, pc_before + 8'(run_len));
		pop_frame(b);
		check_byte("o_tx cycle byte", b, 8'(en_total));
		for (int i = 0; i < `DU_NUM_REGS; i++)
		begin
			pop_word(w);
			check_word($sformatf("o_tx register %0d", i), w, regs[i]);
		end
		for (int i = 0; i < `DU_MEM_WORDS; i++)
		begin
			if (mem_dirty[i])
			begin
				pop_frame(b);
				check_addr("o_tx memory address byte", b, ADDR_W'(i));
				pop_word(w);
				check_word($sformatf("o_tx memory word %0d", i), w, mem[i]);
			end
		end
		wait_read_idle();
		expect_quiet("after the dump");
	endtask

	initial
	begin
		logic [7:0] junk;
		i_reset = 1'b1;
		i_rx = 1'b1; // idle line
		randomize_model();
		repeat (10) @(posedge i_clock);
		i_reset <= 1'b0;
		@(posedge i_clock);

		load_program();

		junk = 8'($random(seed));
		if (junk == mode_step || junk == mode_continue)
			junk = junk ^ 8'h80;
		send_serial_byte(junk);
		expect_quiet("after an unknown mode byte");

		run_and_check(mode_step);
		run_and_check(mode_continue);
		for (int i = 0; i < 8; i++)
		begin
			if (rand_range(0, 1) == 0)
				run_and_check(mode_step);
			else
				run_and_check(mode_continue);
		end

		$display(">>> PASS");
		$finish;
	end
endmodule

// ==== all.f ====
+incdir+verilog
verilog/debug_pkg.sv
verilog/du_byte_if.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/du_loader.sv
verilog/du_controller.sv
verilog/debug_unit.sv
verification/debug_unit_properties.sv
verification/debug_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
	--top-module debug_unit_tb -f all.f --Mdir obj_dir -o debug_unit_sim > build.log 2>&1 &&
./obj_dir/debug_unit_sim > sim.log 2>&1 &&
! grep -q ">>> FAIL" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }
